//--- design/mode_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_consts.svh"

module mode_control (
	input  wire              clk50m_bufg,
	input  wire              reset,
	input  wire video_pkg::mode_t stable_code,
	output video_pkg::mode_t active_mode, // Mode the raster runs on
	output logic             restart      // Holds the raster at the origin
);
	import video_pkg::*;

	localparam int unsigned SETTLE_MAX = `SETTLE_CYCLES - 1;
	localparam int unsigned TMR_W      = $clog2(`SETTLE_CYCLES);

	typedef enum logic [1:0] {
		ST_RUN,
		ST_SETTLE,
		ST_LOAD
	} state_t;

	state_t            state;
	mode_t             pending;    // Code waiting for the settle period
	logic [TMR_W-1:0]  settle_tmr;

	////////////////////////////////////////////////////////////
	// Mode change sequencer
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (reset) begin
			state       <= ST_RUN;
			pending     <= `MODE_VGA;
			settle_tmr  <= '0;
			active_mode <= `MODE_VGA;
			restart     <= 1'b0;
		end else begin
			case (state)
				ST_RUN: begin
					if (stable_code != active_mode) begin
						state      <= ST_SETTLE;
						pending    <= stable_code;
						settle_tmr <= '0;
						restart    <= 1'b1; // Freeze raster while clocks would retune
					end
				end

				ST_SETTLE: begin
					if (stable_code != pending) begin
						pending    <= stable_code; // Code moved again, start over
						settle_tmr <= '0;
					end else if (settle_tmr == SETTLE_MAX[TMR_W-1:0]) begin
						state <= ST_LOAD;
					end else begin
						settle_tmr <= settle_tmr + 1'b1;
					end
				end

				ST_LOAD: begin
					active_mode <= pending; // New thresholds from here on
					restart     <= 1'b0;    // Raster starts at hcount 0 next cycle
					state       <= ST_RUN;
				end

				default: begin
					state   <= ST_RUN;
					restart <= 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/mode_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_consts.svh"

module mode_table (
	input  wire video_pkg::mode_t   active_mode,
	output video_pkg::timing_t      timing
);
	import video_pkg::*;

	// Builds the cumulative thresholds from porch and pulse sizes
	function automatic timing_t mode_timing(
		input count_t pix,
		input count_t hfp,
		input count_t hsw,
		input count_t hbp,
		input count_t lin,
		input count_t vfp,
		input count_t vsw,
		input count_t vbp,
		input logic   neg
	);
		timing_t t;
		t.hsblnk        = pix - 11'd1;
		t.hssync        = t.hsblnk + hfp;
		t.hesync        = t.hssync + hsw;
		t.heblnk        = t.hesync + hbp;
		t.vsblnk        = lin - 11'd1;
		t.vssync        = t.vsblnk + vfp;
		t.vesync        = t.vssync + vsw;
		t.veblnk        = t.vesync + vbp;
		t.negative_sync = neg;
		return t;
	endfunction

	////////////////////////////////////////////////////////////
	// Mode lookup
	////////////////////////////////////////////////////////////
	always_comb begin
		case (active_mode)
			`MODE_VGA: // Negative syncs
				timing = mode_timing(`HPIX_VGA, `HFP_VGA, `HSW_VGA, `HBP_VGA,
					`VLIN_VGA, `VFP_VGA, `VSW_VGA, `VBP_VGA, 1'b1);
			`MODE_SVGA:
				timing = mode_timing(`HPIX_SVGA, `HFP_SVGA, `HSW_SVGA, `HBP_SVGA,
					`VLIN_SVGA, `VFP_SVGA, `VSW_SVGA, `VBP_SVGA, 1'b0);
			`MODE_XGA: // Negative syncs
				timing = mode_timing(`HPIX_XGA, `HFP_XGA, `HSW_XGA, `HBP_XGA,
					`VLIN_XGA, `VFP_XGA, `VSW_XGA, `VBP_XGA, 1'b1);
			`MODE_SXGA:
				timing = mode_timing(`HPIX_SXGA, `HFP_SXGA, `HSW_SXGA, `HBP_SXGA,
					`VLIN_SXGA, `VFP_SXGA, `VSW_SXGA, `VBP_SXGA, 1'b0);
			`MODE_CAMERA:
				timing = mode_timing(`HPIX_CAMERA, `HFP_CAMERA, `HSW_CAMERA,
					`HBP_CAMERA, `VLIN_CAMERA, `VFP_CAMERA, `VSW_CAMERA,
					`VBP_CAMERA, 1'b0);
			default: // 720p, also catches unlisted codes
				timing = mode_timing(`HPIX_720P, `HFP_720P, `HSW_720P, `HBP_720P,
					`VLIN_720P, `VFP_720P, `VSW_720P, `VBP_720P, 1'b0);
		endcase
	end

endmodule

`default_nettype wire

//--- design/raster_counter.sv
`timescale 1ns/1ps
`default_nettype none

module raster_counter (
	input  wire                   clk50m_bufg,
	input  wire                   reset,
	input  wire                   restart, // Hold at the origin
	input  wire video_pkg::timing_t timing,
	output video_pkg::count_t     hcount,
	output video_pkg::count_t     vcount,
	output logic                  hblnk,
	output logic                  vblnk,
	output logic                  hsync_raw, // Active high, polarity applied later
	output logic                  vsync_raw
);
	import video_pkg::*;

	count_t hcount_next;
	count_t vcount_next;
	logic   line_end;
	logic   frame_end;

	assign line_end  = (hcount == timing.heblnk);
	assign frame_end = (vcount == timing.veblnk);

	// Next position, line wraps drive the vertical count
	always_comb begin
		hcount_next = line_end ? '0 : hcount + 11'd1;
		vcount_next = vcount;
		if (line_end) begin
			vcount_next = frame_end ? '0 : vcount + 11'd1;
		end
	end

	always_ff @(posedge clk50m_bufg) begin
		if (reset || restart) begin
			hcount <= '0;
			vcount <= '0;
		end else begin
			hcount <= hcount_next;
			vcount <= vcount_next;
		end
	end

	////////////////////////////////////////////////////////////
	// Threshold compares
	////////////////////////////////////////////////////////////
	assign hblnk     = (hcount > timing.hsblnk);
	assign hsync_raw = (hcount > timing.hssync) && (hcount <= timing.hesync);
	assign vblnk     = (vcount > timing.vsblnk);
	assign vsync_raw = (vcount > timing.vssync) && (vcount <= timing.vesync);

endmodule

`default_nettype wire

//--- design/switch_debouncer.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_consts.svh"

module switch_debouncer (
	input  wire              clk50m_bufg,
	input  wire              reset,
	input  wire video_pkg::mode_t switches, // Straight from the pins, asynchronous
	output video_pkg::mode_t stable_code
);
	import video_pkg::*;

	localparam int unsigned HOLD_MAX = `DEBOUNCE_CYCLES - 1;
	localparam int unsigned CNT_W    = $clog2(`DEBOUNCE_CYCLES);

	mode_t             sync_s1; // Metastability stage
	mode_t             sync_s2;
	mode_t             sample;  // Code being timed
	logic [CNT_W-1:0]  hold_cnt;

	// Two flop synchronizer
	always_ff @(posedge clk50m_bufg) begin
		if (reset) begin
			sync_s1 <= `MODE_VGA;
			sync_s2 <= `MODE_VGA;
		end else begin
			sync_s1 <= switches;
			sync_s2 <= sync_s1;
		end
	end

	// Any change restarts the hold count
	always_ff @(posedge clk50m_bufg) begin
		if (reset) begin
			sample      <= `MODE_VGA;
			hold_cnt    <= '0;
			stable_code <= `MODE_VGA;
		end else if (sync_s2 != sample) begin
			sample   <= sync_s2; // Bounce or real edge, start timing
			hold_cnt <= '0;
		end else if (hold_cnt == HOLD_MAX[CNT_W-1:0]) begin
			stable_code <= sample; // Held long enough
		end else begin
			hold_cnt <= hold_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- design/sync_output.sv
`timescale 1ns/1ps
`default_nettype none

module sync_output (
	input  wire  clk50m_bufg,
	input  wire  reset,
	input  wire  hblnk,
	input  wire  vblnk,
	input  wire  hsync_raw,
	input  wire  vsync_raw,
	input  wire  negative_sync, // From the mode table
	output logic hsync,
	output logic vsync,
	output logic de
);

	logic hsync_q; // First alignment stage
	logic vsync_q;
	logic de_q;

	// Two register delay, outputs line up with the pixel pipe
	always_ff @(posedge clk50m_bufg) begin
		if (reset) begin
			hsync_q <= negative_sync; // Inactive level
			vsync_q <= negative_sync;
			de_q    <= 1'b0;
			hsync   <= negative_sync;
			vsync   <= negative_sync;
			de      <= 1'b0;
		end else begin
			hsync_q <= hsync_raw ^ negative_sync;
			vsync_q <= vsync_raw ^ negative_sync;
			de_q    <= !hblnk && !vblnk; // Active area only
			hsync   <= hsync_q;
			vsync   <= vsync_q;
			de      <= de_q;
		end
	end

endmodule

`default_nettype wire

//--- design/video_pkg.sv
`default_nettype none

package video_pkg;

	// Pixel or line count, 11 bits covers every listed raster
	typedef logic [10:0] count_t;

	// Raw switch code, unlisted codes stay representable
	typedef logic [3:0] mode_t;

	// Cumulative thresholds, each counted from zero
	typedef struct packed {
		count_t hsblnk; // Last active pixel
		count_t hssync; // End of front porch
		count_t hesync; // End of sync pulse
		count_t heblnk; // Last pixel of the line
		count_t vsblnk; // Last active line
		count_t vssync;
		count_t vesync;
		count_t veblnk; // Last line of the frame
		logic   negative_sync; // 1 for active-low syncs
	} timing_t;

endpackage

`default_nettype wire

//--- design/video_timing_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing_top (
	input  wire              clk50m_bufg, // Stands in for the pixel clock
	input  wire              reset,
	input  wire video_pkg::mode_t switches,
	output logic             hsync,
	output logic             vsync,
	output logic             de
);
	import video_pkg::*;

	mode_t   stable_code;
	mode_t   active_mode;
	logic    restart;
	timing_t timing;
	logic    hblnk;
	logic    vblnk;
	logic    hsync_raw;
	logic    vsync_raw;

	////////////////////////////////////////////////////////////
	// Mode selection
	////////////////////////////////////////////////////////////
	switch_debouncer u_debouncer (
		.clk50m_bufg (clk50m_bufg),
		.reset       (reset),
		.switches    (switches),
		.stable_code (stable_code)
	);

	mode_control u_mode_control (
		.clk50m_bufg (clk50m_bufg),
		.reset       (reset),
		.stable_code (stable_code),
		.active_mode (active_mode),
		.restart     (restart)
	);

	mode_table u_mode_table (
		.active_mode (active_mode),
		.timing      (timing)
	);

	////////////////////////////////////////////////////////////
	// Raster and sync generation
	////////////////////////////////////////////////////////////
	raster_counter u_raster (
		.clk50m_bufg (clk50m_bufg),
		.reset       (reset),
		.restart     (restart),
		.timing      (timing),
		.hcount      (), // Kept for a later pixel data path
		.vcount      (),
		.hblnk       (hblnk),
		.vblnk       (vblnk),
		.hsync_raw   (hsync_raw),
		.vsync_raw   (vsync_raw)
	);

	sync_output u_sync_out (
		.clk50m_bufg   (clk50m_bufg),
		.reset         (reset),
		.hblnk         (hblnk),
		.vblnk         (vblnk),
		.hsync_raw     (hsync_raw),
		.vsync_raw     (vsync_raw),
		.negative_sync (timing.negative_sync),
		.hsync         (hsync),
		.vsync         (vsync),
		.de            (de)
	);

endmodule

`default_nettype wire

//--- include/video_consts.svh
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

////////////////////////////////////////////////////////////
// Switch codes
////////////////////////////////////////////////////////////
`define MODE_VGA    4'b0000
`define MODE_SVGA   4'b0001
`define MODE_720P   4'b0010
`define MODE_XGA    4'b0011
`define MODE_SXGA   4'b1000
`define MODE_CAMERA 4'b1001

////////////////////////////////////////////////////////////
// Raster sizes, 60 Hz figures
////////////////////////////////////////////////////////////
// 640x480
`define HPIX_VGA 11'd640
`define HFP_VGA  11'd16
`define HSW_VGA  11'd96
`define HBP_VGA  11'd48
`define VLIN_VGA 11'd480
`define VFP_VGA  11'd11
`define VSW_VGA  11'd2
`define VBP_VGA  11'd31

// 800x600
`define HPIX_SVGA 11'd800
`define HFP_SVGA  11'd40
`define HSW_SVGA  11'd128
`define HBP_SVGA  11'd88
`define VLIN_SVGA 11'd600
`define VFP_SVGA  11'd1
`define VSW_SVGA  11'd4
`define VBP_SVGA  11'd23

// 1024x768
`define HPIX_XGA 11'd1024
`define HFP_XGA  11'd24
`define HSW_XGA  11'd136
`define HBP_XGA  11'd160
`define VLIN_XGA 11'd768
`define VFP_XGA  11'd3
`define VSW_XGA  11'd6
`define VBP_XGA  11'd29

// 1280x720, also the fallback
`define HPIX_720P 11'd1280
`define HFP_720P  11'd110
`define HSW_720P  11'd40
`define HBP_720P  11'd220
`define VLIN_720P 11'd720
`define VFP_720P  11'd5
`define VSW_720P  11'd5
`define VBP_720P  11'd20

// 1280x1024
`define HPIX_SXGA 11'd1280
`define HFP_SXGA  11'd48
`define HSW_SXGA  11'd112
`define HBP_SXGA  11'd248
`define VLIN_SXGA 11'd1024
`define VFP_SXGA  11'd1
`define VSW_SXGA  11'd3
`define VBP_SXGA  11'd38

// Camera, 720p with trimmed sync
`define HPIX_CAMERA 11'd1280
`define HFP_CAMERA  11'd110
`define HSW_CAMERA  11'd39
`define HBP_CAMERA  11'd220
`define VLIN_CAMERA 11'd720
`define VFP_CAMERA  11'd4
`define VSW_CAMERA  11'd4
`define VBP_CAMERA  11'd22

////////////////////////////////////////////////////////////
// Control timing, in clk50m_bufg cycles
////////////////////////////////////////////////////////////
`define DEBOUNCE_CYCLES 8
`define SETTLE_CYCLES   16 // Same depth as an SRL16 delay

`endif

//--- list.f
+incdir+include
design/video_pkg.sv
design/switch_debouncer.sv
design/mode_control.sv
design/mode_table.sv
design/raster_counter.sv
design/sync_output.sv
design/video_timing_top.sv
tests/tb_video_timing.sv

//--- run_sim.sh
#!/bin/sh
# Builds the video timing testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_video_timing -f list.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vtb_video_timing
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

echo "Simulation finished cleanly"
exit 0

//--- tests/tb_video_timing.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_consts.svh"

module tb_video_timing;
	import video_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int NUM_ROWS     = 7;
	localparam int NUM_BOUNCES  = 3;
	localparam int RAND_SEED    = 62;
	// Sync stages, hold count, settle timer, load and output pipe, margin
	localparam int SWITCH_CYCLES = 2 + `DEBOUNCE_CYCLES + 2 + `SETTLE_CYCLES + 4 + 8;
	localparam int BOUNCE_MAX    = NUM_BOUNCES * (2 * `DEBOUNCE_CYCLES + 1);

	logic   clk50m_bufg = 1'b0;
	logic   reset;
	mode_t  switches;
	logic   hsync;
	logic   vsync;
	logic   de;
	longint cycle_cnt   = 0; // Free running, read on falling edges
	logic   table_ready = 1'b0;

	// Stimulus table, one row per switch code
	mode_t row_code  [NUM_ROWS];
	int    row_pix   [NUM_ROWS]; // Active pixels
	int    row_line  [NUM_ROWS]; // heblnk + 1
	int    row_sw    [NUM_ROWS]; // hsync width
	logic  row_neg   [NUM_ROWS]; // 1 for active-low syncs
	int    row_lines [NUM_ROWS]; // veblnk + 1
	logic  row_frame [NUM_ROWS]; // Measure vsync period too

	video_timing_top UUT (
		.clk50m_bufg (clk50m_bufg),
		.reset       (reset),
		.switches    (switches),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de)
	);

	always #10 clk50m_bufg = ~clk50m_bufg; // 50 MHz

	always @(posedge clk50m_bufg) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////
	task automatic check_equal(input longint actual, input longint expected, input string what);
		if (actual != expected) begin
			$display("FAILED at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
			$display("Checks failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// Cumulative thresholds from porch and pulse sizes
	task automatic fill_row(input int idx, input mode_t code, input int pix, input int fp,
		input int sw, input int bp, input int lin, input int vfp, input int vsw,
		input int vbp, input logic neg, input logic frame);
		int heblnk;
		int veblnk;
		heblnk = (pix - 1) + fp + sw + bp;
		veblnk = (lin - 1) + vfp + vsw + vbp;
		row_code[idx]  = code;
		row_pix[idx]   = pix;
		row_line[idx]  = heblnk + 1;
		row_sw[idx]    = sw;
		row_neg[idx]   = neg;
		row_lines[idx] = veblnk + 1;
		row_frame[idx] = frame;
	endtask

	// Returns on the first falling edge that shows a sync leading edge
	task automatic wait_sync_lead(input logic vertical, input logic neg, output longint stamp);
		logic prev;
		logic cur;
		@(negedge clk50m_bufg);
		prev = vertical ? vsync : hsync;
		@(negedge clk50m_bufg);
		cur = vertical ? vsync : hsync;
		while (!(prev == neg && cur != neg)) begin
			prev = cur;
			@(negedge clk50m_bufg);
			cur = vertical ? vsync : hsync;
		end
		stamp = cycle_cnt;
	endtask

	// Starts on a leading edge, runs up to the next one
	task automatic measure_line(input logic neg, output int pix_run, output int width,
		output longint t_next);
		logic prev;
		logic in_pulse;
		logic done;
		pix_run  = 0;
		width    = 1; // Leading edge sample
		in_pulse = 1'b1;
		done     = 1'b0;
		prev     = hsync;
		while (!done) begin
			@(negedge clk50m_bufg);
			if (prev == neg && hsync != neg) begin
				done = 1'b1;
			end else begin
				if (de) begin
					pix_run++;
					check_equal(hsync, neg, "hsync level during active video");
				end
				if (in_pulse && hsync != neg) begin
					width++;
				end else begin
					in_pulse = 1'b0;
				end
			end
			prev = hsync;
		end
		t_next = cycle_cnt;
	endtask

	// Short glitches to random codes, each below the debounce length
	task automatic inject_bounces(input mode_t code);
		mode_t glitch;
		int    len;
		int    gap;
		for (int k = 0; k < NUM_BOUNCES; k++) begin
			glitch = 4'($urandom_range(15, 0));
			if (glitch == code) begin
				glitch = ~code;
			end
			len = $urandom_range(`DEBOUNCE_CYCLES - 1, 1);
			gap = $urandom_range(`DEBOUNCE_CYCLES, 1);
			@(posedge clk50m_bufg);
			switches <= glitch;
			repeat (len) @(posedge clk50m_bufg);
			switches <= code;
			repeat (gap) @(posedge clk50m_bufg);
		end
	endtask

	task automatic run_row(input int r);
		longint t_lead;
		longint t_next;
		longint t_frame;
		int     pix_run;
		int     width;
		logic   neg;
		neg = row_neg[r];
		@(posedge clk50m_bufg);
		switches <= row_code[r];
		repeat (SWITCH_CYCLES) @(posedge clk50m_bufg); // Restart is over by now
		wait_sync_lead(1'b0, neg, t_lead);
		measure_line(neg, pix_run, width, t_next);
		check_equal(pix_run, row_pix[r], $sformatf("mode %b active pixels", row_code[r]));
		check_equal(t_next - t_lead, row_line[r], $sformatf("mode %b line length", row_code[r]));
		check_equal(width, row_sw[r], $sformatf("mode %b hsync width", row_code[r]));

		// A passed glitch would restart the raster inside this line
		inject_bounces(row_code[r]);
		wait_sync_lead(1'b0, neg, t_lead);
		check_equal(t_lead - t_next, row_line[r],
			$sformatf("mode %b line length across bounces", row_code[r]));

		if (row_frame[r]) begin
			wait_sync_lead(1'b1, neg, t_frame);
			wait_sync_lead(1'b1, neg, t_lead);
			check_equal(t_lead - t_frame, row_line[r] * row_lines[r],
				$sformatf("mode %b frame length", row_code[r]));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial begin
		reset    = 1'b1;
		switches = `MODE_VGA;
		void'($urandom(RAND_SEED));
		fill_row(0, `MODE_SVGA, `HPIX_SVGA, `HFP_SVGA, `HSW_SVGA, `HBP_SVGA,
			`VLIN_SVGA, `VFP_SVGA, `VSW_SVGA, `VBP_SVGA, 1'b0, 1'b0);
		fill_row(1, `MODE_XGA, `HPIX_XGA, `HFP_XGA, `HSW_XGA, `HBP_XGA,
			`VLIN_XGA, `VFP_XGA, `VSW_XGA, `VBP_XGA, 1'b1, 1'b0);
		fill_row(2, `MODE_720P, `HPIX_720P, `HFP_720P, `HSW_720P, `HBP_720P,
			`VLIN_720P, `VFP_720P, `VSW_720P, `VBP_720P, 1'b0, 1'b0);
		fill_row(3, `MODE_SXGA, `HPIX_SXGA, `HFP_SXGA, `HSW_SXGA, `HBP_SXGA,
			`VLIN_SXGA, `VFP_SXGA, `VSW_SXGA, `VBP_SXGA, 1'b0, 1'b0);
		fill_row(4, `MODE_CAMERA, `HPIX_CAMERA, `HFP_CAMERA, `HSW_CAMERA, `HBP_CAMERA,
			`VLIN_CAMERA, `VFP_CAMERA, `VSW_CAMERA, `VBP_CAMERA, 1'b0, 1'b0);
		fill_row(5, 4'b0111, `HPIX_720P, `HFP_720P, `HSW_720P, `HBP_720P, // Falls back to 720p
			`VLIN_720P, `VFP_720P, `VSW_720P, `VBP_720P, 1'b0, 1'b0);
		fill_row(6, `MODE_VGA, `HPIX_VGA, `HFP_VGA, `HSW_VGA, `HBP_VGA,
			`VLIN_VGA, `VFP_VGA, `VSW_VGA, `VBP_VGA, 1'b1, 1'b1);
		table_ready = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk50m_bufg);
		reset <= 1'b0;
		@(negedge clk50m_bufg);
		check_equal(de, 1'b0, "de after reset");
		check_equal(hsync, 1'b1, "hsync after reset"); // VGA inactive level
		check_equal(vsync, 1'b1, "vsync after reset");

		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(r);
		end

		$display("All checks passed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Watchdog
	////////////////////////////////////////////////////////////
	initial begin : watchdog
		longint limit;
		int     max_line;
		wait (table_ready);
		max_line = 0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			if (row_line[r] > max_line) begin
				max_line = row_line[r];
			end
		end
		limit = RESET_CYCLES + 1000; // Margin
		for (int r = 0; r < NUM_ROWS; r++) begin
			limit += SWITCH_CYCLES + BOUNCE_MAX + 3 * max_line;
			if (row_frame[r]) begin
				limit += 2 * row_line[r] * row_lines[r]; // Up to two vsync periods
			end
		end
		repeat (limit) @(posedge clk50m_bufg);
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("Checks failed");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire
